// File: src/axi_consts.svh
`ifndef AXI_CONSTS_SVH
`define AXI_CONSTS_SVH

// Channel field widths
`define AXI_ID_BITS 4
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4
`define AXI_LEN_BITS 4
`define AXI_SIZE_BITS 3

// Burst encoding used by this subsystem
`define AXI_BURST_INC 2'b01

// On-chip memory depth in words
`define MEM_WORDS 256

`endif

// File: src/axi_pkg.sv
`include "axi_consts.svh"

package axi_pkg;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_t;

  // Beats minus one
  typedef logic [`AXI_LEN_BITS-1:0] axi_len_t;

  // Log2 of bytes per beat
  typedef logic [`AXI_SIZE_BITS-1:0] axi_size_t;

endpackage

// File: src/mem_op_pkg.sv
package mem_op_pkg;

  // Store width, reads always return whole words
  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } mem_width_t;

  typedef enum logic {
    WR_DISABLE = 1'b0,
    WR_ENABLE  = 1'b1
  } wr_en_t;

  localparam int IDLE_BIT = 0;
  localparam int AR_BIT = 1;
  localparam int R_BIT = 2;
  localparam int AW_BIT = 3;
  localparam int W_BIT = 4;
  localparam int B_BIT = 5;

  typedef enum logic [5:0] {
    IDLE = 6'b1 << IDLE_BIT,
    AR   = 6'b1 << AR_BIT,
    R    = 6'b1 << R_BIT,
    AW   = 6'b1 << AW_BIT,
    W    = 6'b1 << W_BIT,
    B    = 6'b1 << B_BIT
  } master_state_t;

endpackage

// File: src/axi_if.sv
`timescale 1ns/1ps
`include "axi_consts.svh"

interface axi_if;
  import axi_pkg::*;

  // Write address
  logic [`AXI_ID_BITS-1:0] awid;
  logic [`AXI_ADDR_BITS-1:0] awaddr;
  axi_len_t awlen;
  axi_size_t awsize;
  burst_t awburst;
  logic awvalid;
  logic awready;

  // Write data and response
  logic [`AXI_DATA_BITS-1:0] wdata;
  logic [`AXI_STRB_BITS-1:0] wstrb;
  logic wlast;
  logic wvalid;
  logic wready;
  logic [`AXI_ID_BITS-1:0] bid;
  resp_t bresp;
  logic bvalid;
  logic bready;

  // Read address and data
  logic [`AXI_ID_BITS-1:0] arid;
  logic [`AXI_ADDR_BITS-1:0] araddr;
  axi_len_t arlen;
  axi_size_t arsize;
  burst_t arburst;
  logic arvalid;
  logic arready;
  logic [`AXI_ID_BITS-1:0] rid;
  logic [`AXI_DATA_BITS-1:0] rdata;
  resp_t rresp;
  logic rlast;
  logic rvalid;
  logic rready;

  modport master(
    output awid, awaddr, awlen, awsize, awburst, awvalid, input awready,
    output wdata, wstrb, wlast, wvalid, input wready,
    input bid, bresp, bvalid, output bready,
    output arid, araddr, arlen, arsize, arburst, arvalid, input arready,
    input rid, rdata, rresp, rlast, rvalid, output rready
  );

  modport slave(
    input awid, awaddr, awlen, awsize, awburst, awvalid, output awready,
    input wdata, wstrb, wlast, wvalid, output wready,
    output bid, bresp, bvalid, input bready,
    input arid, araddr, arlen, arsize, arburst, arvalid, output arready,
    output rid, rdata, rresp, rlast, rvalid, input rready
  );

endinterface

// File: src/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if;
  import axi_pkg::*;
  import mem_op_pkg::*;

  logic req;
  logic write;
  mem_width_t width;
  logic [31:0] addr;
  logic [31:0] wdata;
  axi_len_t blk_len;

  // Returned to the cache
  logic [31:0] rdata;
  logic ack;

  modport requester(
    output req, write, width, addr, wdata, blk_len,
    input rdata, ack
  );

  modport memory(
    input req, write, width, addr, wdata, blk_len,
    output rdata, ack
  );

endinterface

// File: src/axi_master.sv
`timescale 1ns/1ps
`include "axi_consts.svh"

module axi_master #(
  parameter logic [`AXI_ID_BITS-1:0] master_id = '0
) (
  input logic clk,
  input logic rstn,
  axi_if.master axi,
  mem_req_if.memory mem
);
  import axi_pkg::*;
  import mem_op_pkg::*;

  master_state_t state_q;
  master_state_t state_d;
  logic [`AXI_STRB_BITS-1:0] strb;
  logic read_req;
  logic write_req;
  logic ar_hs;
  logic r_hs;
  logic aw_hs;
  logic w_hs;

  assign read_req = mem.req & ~mem.write;
  assign write_req = mem.req & mem.write;

  assign ar_hs = axi.arvalid & axi.arready;
  assign r_hs = axi.rvalid & axi.rready;
  assign aw_hs = axi.awvalid & axi.awready;
  assign w_hs = axi.wvalid & axi.wready;

  // Whole words go back to the core
  assign mem.rdata = axi.rdata;

  // Byte lanes enabled by store width and address
  always_comb begin
    strb = {WR_DISABLE, WR_DISABLE, WR_DISABLE, WR_DISABLE};
    case (mem.width)
      WORD: strb = {WR_ENABLE, WR_ENABLE, WR_ENABLE, WR_ENABLE};
      HALF: begin
        if (mem.addr[1]) begin
          strb = {WR_ENABLE, WR_ENABLE, WR_DISABLE, WR_DISABLE};
        end else begin
          strb = {WR_DISABLE, WR_DISABLE, WR_ENABLE, WR_ENABLE};
        end
      end
      BYTE: strb[mem.addr[1:0]] = WR_ENABLE;
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Leaving R or B always passes through IDLE
  always_comb begin
    state_d = state_q;
    unique case (1'b1)
      state_q[IDLE_BIT]: state_d = write_req ? AW : (read_req ? AR : IDLE);
      state_q[AR_BIT]: state_d = ar_hs ? R : AR;
      state_q[R_BIT]: state_d = (r_hs && axi.rlast) ? IDLE : R;
      state_q[AW_BIT]: begin
        if (aw_hs) begin
          state_d = w_hs ? B : W;
        end
      end
      state_q[W_BIT]: state_d = w_hs ? B : W;
      state_q[B_BIT]: state_d = axi.bvalid ? IDLE : B;
      default: state_d = IDLE;
    endcase
  end

  always_comb begin
    axi.awid = master_id;
    axi.awaddr = mem.addr;
    axi.awlen = axi_len_t'(0);
    axi.awsize = axi_size_t'(2);
    axi.awburst = burst_t'(`AXI_BURST_INC);
    axi.awvalid = 1'b0;
    axi.wdata = mem.wdata;
    axi.wstrb = strb;
    axi.wlast = 1'b1;
    axi.wvalid = 1'b0;
    axi.bready = 1'b0;
    axi.arid = master_id;
    axi.araddr = mem.addr;
    axi.arlen = mem.blk_len;
    axi.arsize = axi_size_t'(2);
    axi.arburst = burst_t'(`AXI_BURST_INC);
    axi.arvalid = 1'b0;
    axi.rready = 1'b0;
    mem.ack = 1'b0;

    unique case (1'b1)
      state_q[AR_BIT]: axi.arvalid = 1'b1;
      state_q[R_BIT]: begin
        axi.rready = 1'b1;
        mem.ack = axi.rvalid;
      end
      state_q[AW_BIT]: begin
        axi.awvalid = 1'b1;
        // W goes out together with the address handshake
        axi.wvalid = aw_hs;
      end
      state_q[W_BIT]: begin
        axi.wvalid = 1'b1;
        axi.bready = 1'b1;
      end
      state_q[B_BIT]: begin
        axi.bready = 1'b1;
        mem.ack = axi.bvalid;
      end
      default: ;
    endcase
  end

endmodule

// File: src/axi_mem_slave.sv
`timescale 1ns/1ps
`include "axi_consts.svh"

module axi_mem_slave (
  input logic clk,
  input logic rstn,
  axi_if.slave axi
);
  import axi_pkg::*;

  localparam int IDX_BITS = $clog2(`MEM_WORDS);

  typedef enum logic [1:0] {
    WS_IDLE,
    WS_DATA,
    WS_RESP
  } wr_state_t;

  typedef enum logic {
    RS_IDLE,
    RS_DATA
  } rd_state_t;

  logic [`AXI_DATA_BITS-1:0] ram [`MEM_WORDS];

  wr_state_t ws_q;
  logic [IDX_BITS-1:0] aw_idx_q;
  logic [`AXI_ID_BITS-1:0] bid_q;
  logic [IDX_BITS-1:0] wr_idx;
  logic aw_hs;
  logic w_hs;

  rd_state_t rs_q;
  logic [IDX_BITS-1:0] rd_idx_q;
  axi_len_t rd_left_q;
  logic [`AXI_ID_BITS-1:0] rid_q;
  logic ar_hs;
  logic r_hs;

  // Write side
  assign axi.awready = (ws_q == WS_IDLE);
  assign axi.wready = (ws_q == WS_DATA) || (ws_q == WS_IDLE && axi.awvalid);
  assign aw_hs = axi.awvalid & axi.awready;
  assign w_hs = axi.wvalid & axi.wready;

  // Address not latched yet when AW and W arrive together
  assign wr_idx = (ws_q == WS_IDLE) ? axi.awaddr[IDX_BITS+1:2] : aw_idx_q;

  assign axi.bvalid = (ws_q == WS_RESP);
  assign axi.bid = bid_q;
  assign axi.bresp = OKAY;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ws_q <= WS_IDLE;
      aw_idx_q <= '0;
      bid_q <= '0;
    end else begin
      if (aw_hs) begin
        aw_idx_q <= axi.awaddr[IDX_BITS+1:2];
        bid_q <= axi.awid;
      end
      case (ws_q)
        WS_IDLE: begin
          if (w_hs) begin
            ws_q <= WS_RESP;
          end else if (aw_hs) begin
            ws_q <= WS_DATA;
          end
        end
        WS_DATA: if (w_hs) ws_q <= WS_RESP;
        WS_RESP: if (axi.bready) ws_q <= WS_IDLE;
        default: ws_q <= WS_IDLE;
      endcase
    end
  end

  // Memory, zeroed at reset, strobed merge per lane
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        ram[i] <= '0;
      end
    end else if (w_hs) begin
      for (int lane = 0; lane < `AXI_STRB_BITS; lane++) begin
        if (axi.wstrb[lane]) begin
          ram[wr_idx][8*lane +: 8] <= axi.wdata[8*lane +: 8];
        end
      end
    end
  end

  // Read side
  assign axi.arready = (rs_q == RS_IDLE);
  assign ar_hs = axi.arvalid & axi.arready;
  assign r_hs = axi.rvalid & axi.rready;

  assign axi.rvalid = (rs_q == RS_DATA);
  assign axi.rdata = ram[rd_idx_q];
  assign axi.rlast = (rd_left_q == '0);
  assign axi.rid = rid_q;
  assign axi.rresp = OKAY;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rs_q <= RS_IDLE;
      rd_idx_q <= '0;
      rd_left_q <= '0;
      rid_q <= '0;
    end else if (ar_hs) begin
      rs_q <= RS_DATA;
      rd_idx_q <= axi.araddr[IDX_BITS+1:2];
      rd_left_q <= axi.arlen;
      rid_q <= axi.arid;
    end else if (r_hs) begin
      if (axi.rlast) begin
        rs_q <= RS_IDLE;
      end else begin
        // Incrementing burst, one word per beat
        rd_idx_q <= rd_idx_q + 1'b1;
        rd_left_q <= rd_left_q - 1'b1;
      end
    end
  end

endmodule

// File: src/mem_subsys_top.sv
`timescale 1ns/1ps
`include "axi_consts.svh"

module mem_subsys_top #(
  parameter logic [`AXI_ID_BITS-1:0] master_id = '0
) (
  input logic clk,
  input logic rstn,
  input logic req,
  input logic write,
  input mem_op_pkg::mem_width_t width,
  input logic [31:0] addr,
  input logic [31:0] wdata,
  input axi_pkg::axi_len_t blk_len,
  output logic [31:0] rdata,
  output logic ack
);

  mem_req_if mreq ();
  axi_if axi ();

  // Cache side request
  assign mreq.req = req;
  assign mreq.write = write;
  assign mreq.width = width;
  assign mreq.addr = addr;
  assign mreq.wdata = wdata;
  assign mreq.blk_len = blk_len;

  assign rdata = mreq.rdata;
  assign ack = mreq.ack;

  axi_master #(
    .master_id(master_id)
  ) u_master (
    .clk (clk),
    .rstn(rstn),
    .axi (axi.master),
    .mem (mreq.memory)
  );

  axi_mem_slave u_slave (
    .clk (clk),
    .rstn(rstn),
    .axi (axi.slave)
  );

endmodule

// File: tests/tb_mem_subsys.sv
`timescale 1ns/1ps
`include "axi_consts.svh"

module tb_mem_subsys;
  import axi_pkg::*;
  import mem_op_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int SEED = 7553;
  localparam int ACK_TIMEOUT = 16;
  localparam int RANDOM_OPS = 200;
  // Directed operations plus the random ones
  localparam int OP_COUNT = 32 + RANDOM_OPS;
  localparam int WATCHDOG_CYCLES = OP_COUNT * 20 + 100;

  logic clk;
  logic rstn;
  logic req;
  logic write;
  mem_width_t width;
  logic [31:0] addr;
  logic [31:0] wdata;
  axi_len_t blk_len;
  logic [31:0] rdata;
  logic ack;

  // Reference copy of the slave memory
  logic [31:0] model [`MEM_WORDS];

  mem_subsys_top uut (
    .clk    (clk),
    .rstn   (rstn),
    .req    (req),
    .write  (write),
    .width  (width),
    .addr   (addr),
    .wdata  (wdata),
    .blk_len(blk_len),
    .rdata  (rdata),
    .ack    (ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAIL t=%0t %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAIL t=%0t %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  function automatic int word_index(input logic [31:0] a);
    return int'(a[31:2]) % `MEM_WORDS;
  endfunction

  // Lanes a store of this width touches
  function automatic logic [3:0] lane_mask(input mem_width_t w, input logic [1:0] off);
    case (w)
      WORD: return 4'b1111;
      HALF: return off[1] ? 4'b1100 : 4'b0011;
      BYTE: return 4'b0001 << off;
      default: return 4'b0000;
    endcase
  endfunction

  function automatic void model_write(input mem_width_t w, input logic [31:0] a,
                                      input logic [31:0] d);
    logic [3:0] mask;
    int idx;
    mask = lane_mask(w, a[1:0]);
    idx = word_index(a);
    for (int l = 0; l < 4; l++) begin
      if (mask[l]) model[idx][8*l +: 8] = d[8*l +: 8];
    end
  endfunction

  task automatic wait_ack(input string what);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (ack !== 1'b1 && waited >= ACK_TIMEOUT) begin
        stop_on_error($sformatf("No ack within %0d cycles for %s", ACK_TIMEOUT, what));
      end
    end while (ack !== 1'b1);
  endtask

  task automatic do_write(input mem_width_t w, input logic [31:0] a, input logic [31:0] d);
    @(posedge clk);
    req <= 1'b1;
    write <= 1'b1;
    width <= w;
    addr <= a;
    wdata <= d;
    blk_len <= '0;
    wait_ack("write");
    model_write(w, a, d);
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    check_bit("ack", 1'b0, ack);
  endtask

  task automatic do_read(input logic [31:0] a, input axi_len_t len, output logic [31:0] first);
    int base;
    base = word_index(a);
    first = '0;
    @(posedge clk);
    req <= 1'b1;
    write <= 1'b0;
    addr <= a;
    wdata <= '0;
    blk_len <= len;
    for (int i = 0; i <= int'(len); i++) begin
      wait_ack($sformatf("read beat %0d", i));
      check_word("rdata", model[(base + i) % `MEM_WORDS], rdata);
      if (i == 0) first = rdata;
    end
    @(posedge clk);
    req <= 1'b0;
    // One more ack here would mean too many beats
    @(negedge clk);
    check_bit("ack", 1'b0, ack);
  endtask

  task automatic test_reset_idle();
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      check_bit("ack", 1'b0, ack);
    end
    @(posedge clk);
    rstn <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_bit("ack", 1'b0, ack);
    end
  endtask

  task automatic test_word_roundtrip();
    logic [31:0] got;
    do_write(WORD, 32'h0000_0020, 32'hDEAD_BEEF);
    do_read(32'h0000_0020, axi_len_t'(0), got);
    check_word("rdata", 32'hDEAD_BEEF, got);
  endtask

  task automatic test_byte_merge();
    logic [31:0] a;
    logic [31:0] got;
    a = 32'h0000_0040;
    do_write(WORD, a - 4, 32'hFFFF_FFFF);
    do_write(WORD, a + 4, 32'hFFFF_FFFF);
    // Junk on the other lanes must not land
    do_write(BYTE, a + 0, {4{8'h11}});
    do_write(BYTE, a + 1, {4{8'h22}});
    do_write(BYTE, a + 2, {4{8'h33}});
    do_write(BYTE, a + 3, {4{8'h44}});
    do_read(a, axi_len_t'(0), got);
    check_word("rdata", 32'h4433_2211, got);
    do_read(a - 4, axi_len_t'(2), got);
    check_word("rdata", 32'hFFFF_FFFF, got);
  endtask

  task automatic test_half_lanes();
    logic [31:0] a;
    logic [31:0] got;
    a = 32'h0000_0080;
    do_write(WORD, a, 32'h1234_5678);
    do_write(HALF, a, {2{16'hBEEF}});
    do_read(a, axi_len_t'(0), got);
    check_word("rdata", 32'h1234_BEEF, got);
    do_write(HALF, a + 2, {2{16'hCAFE}});
    do_read(a, axi_len_t'(0), got);
    check_word("rdata", 32'hCAFE_BEEF, got);
  endtask

  task automatic test_burst_read();
    logic [31:0] base;
    logic [31:0] got;
    base = 32'h0000_0100;
    for (int i = 0; i < 8; i++) begin
      do_write(WORD, base + 32'(4 * i), 32'hA000_0000 + 32'(i));
    end
    do_read(base, axi_len_t'(7), got);
    check_word("rdata", 32'hA000_0000, got);
  endtask

  task automatic test_random_ops();
    axi_len_t len;
    mem_width_t w;
    int idx;
    logic [1:0] off;
    logic [31:0] a;
    logic [31:0] got;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      len = axi_len_t'($urandom_range(0, 15));
      // Keep the whole burst inside the memory
      idx = int'($urandom_range(0, `MEM_WORDS - 1 - int'(len)));
      off = 2'($urandom);
      a = {idx[29:0], off};
      if ($urandom_range(0, 1) == 1) begin
        w = mem_width_t'($urandom_range(0, 2));
        do_write(w, a, $urandom);
      end else begin
        do_read(a, len, got);
      end
    end
  endtask

  always @(negedge clk) begin
    if (rstn === 1'b1 && ack === 1'b1 && req !== 1'b1) begin
      stop_on_error("Ack raised with no request pending");
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_on_error($sformatf("Watchdog expired after %0d cycles", WATCHDOG_CYCLES));
  end

  initial begin
    rstn <= 1'b0;
    req <= 1'b0;
    write <= 1'b0;
    width <= WORD;
    addr <= '0;
    wdata <= '0;
    blk_len <= '0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      model[i] = '0;
    end
    void'($urandom(SEED));

    test_reset_idle();
    test_word_roundtrip();
    test_byte_merge();
    test_half_lanes();
    test_burst_read();
    test_random_ops();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: flist.f
+incdir+src
src/axi_pkg.sv
src/mem_op_pkg.sv
src/axi_if.sv
src/mem_req_if.sv
src/axi_master.sv
src/axi_mem_slave.sv
src/mem_subsys_top.sv
tests/tb_mem_subsys.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_mem_subsys
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
